// File: flist.f
+incdir+logic
logic/mem_pkg.sv
logic/jbus_if.sv
logic/wb_if.sv
logic/jbus_tcm_decoder.sv
logic/tcm_dualport.sv
logic/jbus_to_wishbone.sv
logic/wishbone_arbiter.sv
logic/mem_subsys_top.sv
verif/tb_mem_subsys.sv

// File: logic/jbus_if.sv
// processor side valid/ready bus with byte lane writes
`timescale 1ns/1ps

interface jbus_if;

	logic valid;
	logic ready;
	mem_pkg::waddr_t addr;
	logic we;
	mem_pkg::sel_t sel;
	mem_pkg::word_t wdata;
	mem_pkg::word_t rdata;

	// request side
	modport master (
		output valid,
		output addr,
		output we,
		output sel,
		output wdata,
		input  ready,
		input  rdata
	);

	// rdata valid from the cycle after acceptance
	modport slave (
		input  valid,
		input  addr,
		input  we,
		input  sel,
		input  wdata,
		output ready,
		output rdata
	);

endinterface

// File: logic/jbus_tcm_decoder.sv
// address decoder steering one bus port to the TCM or the non-cached path
`timescale 1ns/1ps

module jbus_tcm_decoder (
	input  logic            clk,
	input  logic            rst_n_i,
	input  mem_pkg::waddr_t addr_mask_i,
	input  mem_pkg::waddr_t addr_value_i,
	jbus_if.slave           host,
	jbus_if.master          tcm,
	jbus_if.master          through
);

	logic hit;
	logic rd_accept;
	mem_pkg::rd_src_e rd_src;

	assign hit = (host.addr & addr_mask_i) == addr_value_i;

	// request fields fan out, valid goes to one target only
	assign tcm.valid = host.valid && hit;
	assign tcm.addr  = host.addr;
	assign tcm.we    = host.we;
	assign tcm.sel   = host.sel;
	assign tcm.wdata = host.wdata;

	assign through.valid = host.valid && !hit;
	assign through.addr  = host.addr;
	assign through.we    = host.we;
	assign through.sel   = host.sel;
	assign through.wdata = host.wdata;

	assign host.ready = hit ? tcm.ready : through.ready;

	// ----------------------------------------------------------------------
	//  read data return
	// ----------------------------------------------------------------------

	assign rd_accept = host.valid && host.ready && !host.we;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rd_src <= mem_pkg::RD_TCM;
		end else if (rd_accept) begin
			rd_src <= hit ? mem_pkg::RD_TCM : mem_pkg::RD_THROUGH;
		end
	end

	// both sources hold their data until their next read
	assign host.rdata = (rd_src == mem_pkg::RD_TCM) ? tcm.rdata : through.rdata;

endmodule

// File: logic/jbus_to_wishbone.sv
// converts one bus request into one Wishbone cycle
`timescale 1ns/1ps

module jbus_to_wishbone (
	input  logic   clk,
	input  logic   rst_n_i,
	jbus_if.slave  host,
	wb_if.master   wb
);

	mem_pkg::wb_state_e state;
	mem_pkg::waddr_t adr_q;
	mem_pkg::word_t dat_w_q;
	mem_pkg::sel_t sel_q;
	logic we_q;
	mem_pkg::word_t rdata_q;
	logic done;

	// ack ends the cycle and accepts the host request
	assign done = (state == mem_pkg::WB_BUSY) && wb.ack;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state <= mem_pkg::WB_IDLE;
		end else begin
			case (state)
				mem_pkg::WB_IDLE: begin
					if (host.valid) begin
						state <= mem_pkg::WB_BUSY;
					end
				end
				mem_pkg::WB_BUSY: begin
					if (wb.ack) begin
						state <= mem_pkg::WB_IDLE;
					end
				end
				default: state <= mem_pkg::WB_IDLE;
			endcase
		end
	end

	// request capture
	always_ff @(posedge clk) begin
		if (state == mem_pkg::WB_IDLE && host.valid) begin
			adr_q   <= host.addr;
			dat_w_q <= host.wdata;
			sel_q   <= host.sel;
			we_q    <= host.we;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rdata_q <= '0;
		end else if (done && !we_q) begin
			rdata_q <= wb.dat_r;
		end
	end

	assign wb.adr   = adr_q;
	assign wb.dat_w = dat_w_q;
	assign wb.sel   = sel_q;
	assign wb.we    = we_q;
	assign wb.stb   = (state == mem_pkg::WB_BUSY);

	assign host.ready = done;
	assign host.rdata = rdata_q;

endmodule

// File: logic/mem_defs.svh
// width definitions shared by the memory subsystem
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// data path
`define MEM_WORD_WIDTH 32
`define MEM_SEL_WIDTH 4

// word address, bits 31 to 2 of a byte address
`define MEM_WADDR_WIDTH 30

// ----------------------------------------------------------------------
//  tightly coupled memory
// ----------------------------------------------------------------------

// 256 words
`define MEM_TCM_ADDR_WIDTH 8

`endif

// File: logic/mem_pkg.sv
// data types and state encodings for the memory subsystem
`include "mem_defs.svh"

package mem_pkg;

	// bus payload
	typedef logic [`MEM_WORD_WIDTH-1:0] word_t;
	typedef logic [`MEM_WADDR_WIDTH-1:0] waddr_t;
	typedef logic [`MEM_SEL_WIDTH-1:0] sel_t;
	typedef logic [`MEM_TCM_ADDR_WIDTH-1:0] tcm_idx_t;

	// where the last accepted read came from
	typedef enum logic {
		RD_TCM,
		RD_THROUGH
	} rd_src_e;

	// bus to wishbone converter
	typedef enum logic {
		WB_IDLE,
		WB_BUSY
	} wb_state_e;

	typedef enum logic [1:0] {
		OWN_NONE,
		OWN_INST,
		OWN_DATA
	} arb_owner_e;

endpackage

// File: logic/mem_subsys_top.sv
// memory subsystem with shared TCM and arbitrated Wishbone peripheral bus
`timescale 1ns/1ps

module mem_subsys_top (
	input  logic            clk,
	input  logic            rst_n_i,

	// TCM address decode, byte addresses
	input  mem_pkg::word_t  tcm_addr_mask_i,
	input  mem_pkg::word_t  tcm_addr_value_i,

	// instruction bus
	input  logic            inst_valid_i,
	output logic            inst_ready_o,
	input  mem_pkg::waddr_t inst_addr_i,
	input  logic            inst_we_i,
	input  mem_pkg::sel_t   inst_sel_i,
	input  mem_pkg::word_t  inst_wdata_i,
	output mem_pkg::word_t  inst_rdata_o,

	// data bus
	input  logic            data_valid_i,
	output logic            data_ready_o,
	input  mem_pkg::waddr_t data_addr_i,
	input  logic            data_we_i,
	input  mem_pkg::sel_t   data_sel_i,
	input  mem_pkg::word_t  data_wdata_i,
	output mem_pkg::word_t  data_rdata_o,

	// Wishbone peripheral bus
	output mem_pkg::waddr_t wb_adr_o,
	output mem_pkg::word_t  wb_dat_o,
	input  mem_pkg::word_t  wb_dat_i,
	output logic            wb_we_o,
	output mem_pkg::sel_t   wb_sel_o,
	output logic            wb_stb_o,
	input  logic            wb_ack_i
);

	jbus_if inst_host ();
	jbus_if data_host ();
	jbus_if inst_tcm ();
	jbus_if data_tcm ();
	jbus_if inst_thr ();
	jbus_if data_thr ();

	wb_if inst_wb ();
	wb_if data_wb ();
	wb_if ext_wb ();

	// ----------------------------------------------------------------------
	//  port wiring
	// ----------------------------------------------------------------------

	assign inst_host.valid = inst_valid_i;
	assign inst_host.addr  = inst_addr_i;
	assign inst_host.we    = inst_we_i;
	assign inst_host.sel   = inst_sel_i;
	assign inst_host.wdata = inst_wdata_i;
	assign inst_ready_o    = inst_host.ready;
	assign inst_rdata_o    = inst_host.rdata;

	assign data_host.valid = data_valid_i;
	assign data_host.addr  = data_addr_i;
	assign data_host.we    = data_we_i;
	assign data_host.sel   = data_sel_i;
	assign data_host.wdata = data_wdata_i;
	assign data_ready_o    = data_host.ready;
	assign data_rdata_o    = data_host.rdata;

	assign wb_adr_o      = ext_wb.adr;
	assign wb_dat_o      = ext_wb.dat_w;
	assign wb_we_o       = ext_wb.we;
	assign wb_sel_o      = ext_wb.sel;
	assign wb_stb_o      = ext_wb.stb;
	assign ext_wb.dat_r  = wb_dat_i;
	assign ext_wb.ack    = wb_ack_i;

	// ----------------------------------------------------------------------
	//  decode, TCM and non-cached path
	// ----------------------------------------------------------------------

	jbus_tcm_decoder u_inst_dec (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.addr_mask_i  (tcm_addr_mask_i[31:2]),
		.addr_value_i (tcm_addr_value_i[31:2]),
		.host         (inst_host.slave),
		.tcm          (inst_tcm.master),
		.through      (inst_thr.master)
	);

	jbus_tcm_decoder u_data_dec (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.addr_mask_i  (tcm_addr_mask_i[31:2]),
		.addr_value_i (tcm_addr_value_i[31:2]),
		.host         (data_host.slave),
		.tcm          (data_tcm.master),
		.through      (data_thr.master)
	);

	// instruction side on port a
	tcm_dualport u_tcm (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.port_a  (inst_tcm.slave),
		.port_b  (data_tcm.slave)
	);

	jbus_to_wishbone u_inst_wb (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.host    (inst_thr.slave),
		.wb      (inst_wb.master)
	);

	jbus_to_wishbone u_data_wb (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.host    (data_thr.slave),
		.wb      (data_wb.master)
	);

	wishbone_arbiter u_arbiter (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.inst_wb (inst_wb.slave),
		.data_wb (data_wb.slave),
		.ext_wb  (ext_wb.master)
	);

endmodule

// File: logic/tcm_dualport.sv
// shared dual port tightly coupled memory with byte lane writes
`timescale 1ns/1ps
`include "mem_defs.svh"

module tcm_dualport (
	input  logic  clk,
	input  logic  rst_n_i,
	jbus_if.slave port_a,
	jbus_if.slave port_b
);

	mem_pkg::word_t mem [1 << `MEM_TCM_ADDR_WIDTH];
	mem_pkg::tcm_idx_t idx_a;
	mem_pkg::tcm_idx_t idx_b;
	mem_pkg::word_t rdata_a;
	mem_pkg::word_t rdata_b;

	// low word address bits only
	assign idx_a = port_a.addr[`MEM_TCM_ADDR_WIDTH-1:0];
	assign idx_b = port_b.addr[`MEM_TCM_ADDR_WIDTH-1:0];

	// never stalls
	assign port_a.ready = 1'b1;
	assign port_b.ready = 1'b1;

	// same word from both ports in one cycle is undefined
	always_ff @(posedge clk) begin
		for (int i = 0; i < `MEM_SEL_WIDTH; i++) begin
			if (port_a.valid && port_a.we && port_a.sel[i]) begin
				mem[idx_a][8*i +: 8] <= port_a.wdata[8*i +: 8];
			end
			if (port_b.valid && port_b.we && port_b.sel[i]) begin
				mem[idx_b][8*i +: 8] <= port_b.wdata[8*i +: 8];
			end
		end
	end

	// read registers, one cycle latency
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rdata_a <= '0;
			rdata_b <= '0;
		end else begin
			if (port_a.valid && !port_a.we) begin
				rdata_a <= mem[idx_a];
			end
			if (port_b.valid && !port_b.we) begin
				rdata_b <= mem[idx_b];
			end
		end
	end

	assign port_a.rdata = rdata_a;
	assign port_b.rdata = rdata_b;

endmodule

// File: logic/wb_if.sv
// single word Wishbone bus with stb/ack handshake
`timescale 1ns/1ps

interface wb_if;

	mem_pkg::waddr_t adr;
	mem_pkg::word_t dat_w;
	mem_pkg::word_t dat_r;
	logic we;
	mem_pkg::sel_t sel;
	logic stb;
	logic ack;

	// master holds stb and fields until ack
	modport master (
		output adr,
		output dat_w,
		output we,
		output sel,
		output stb,
		input  dat_r,
		input  ack
	);

	modport slave (
		input  adr,
		input  dat_w,
		input  we,
		input  sel,
		input  stb,
		output dat_r,
		output ack
	);

endinterface

// File: logic/wishbone_arbiter.sv
// merges instruction and data Wishbone masters onto one bus
`timescale 1ns/1ps

module wishbone_arbiter (
	input  logic clk,
	input  logic rst_n_i,
	wb_if.slave  inst_wb,
	wb_if.slave  data_wb,
	wb_if.master ext_wb
);

	mem_pkg::arb_owner_e owner_q;
	mem_pkg::arb_owner_e cur_owner;

	// a free bus is granted in the same cycle, data first
	always_comb begin
		cur_owner = owner_q;
		if (owner_q == mem_pkg::OWN_NONE) begin
			if (data_wb.stb) begin
				cur_owner = mem_pkg::OWN_DATA;
			end else if (inst_wb.stb) begin
				cur_owner = mem_pkg::OWN_INST;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			owner_q <= mem_pkg::OWN_NONE;
		end else if (ext_wb.ack) begin
			owner_q <= mem_pkg::OWN_NONE;
		end else begin
			owner_q <= cur_owner;
		end
	end

	// ----------------------------------------------------------------------
	//  bus multiplexing
	// ----------------------------------------------------------------------

	always_comb begin
		ext_wb.adr   = '0;
		ext_wb.dat_w = '0;
		ext_wb.we    = 1'b0;
		ext_wb.sel   = '0;
		ext_wb.stb   = 1'b0;
		case (cur_owner)
			mem_pkg::OWN_INST: begin
				ext_wb.adr   = inst_wb.adr;
				ext_wb.dat_w = inst_wb.dat_w;
				ext_wb.we    = inst_wb.we;
				ext_wb.sel   = inst_wb.sel;
				ext_wb.stb   = inst_wb.stb;
			end
			mem_pkg::OWN_DATA: begin
				ext_wb.adr   = data_wb.adr;
				ext_wb.dat_w = data_wb.dat_w;
				ext_wb.we    = data_wb.we;
				ext_wb.sel   = data_wb.sel;
				ext_wb.stb   = data_wb.stb;
			end
			default: begin
			end
		endcase
	end

	// responses only to the owner
	assign inst_wb.ack   = ext_wb.ack && (cur_owner == mem_pkg::OWN_INST);
	assign data_wb.ack   = ext_wb.ack && (cur_owner == mem_pkg::OWN_DATA);
	assign inst_wb.dat_r = (cur_owner == mem_pkg::OWN_INST) ? ext_wb.dat_r : '0;
	assign data_wb.dat_r = (cur_owner == mem_pkg::OWN_DATA) ? ext_wb.dat_r : '0;

endmodule

// File: run.sh
#!/bin/sh
# builds the memory subsystem testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_mem_subsys -o sim_tb \
	> build.log 2>&1 \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	|| { cat build.log; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "Result: FAILED" sim.log && exit 1 || exit 0

// File: verif/mem_vectors.txt
# name port op word_addr sel wdata expected_rdata
# op dec loads the TCM decode value (byte address) from the wdata column
tcm_full_write data wr 00000020 f 11223344 00000000
tcm_lane_write data wr 00000020 5 aabbccdd 00000000
tcm_merged_read data rd 00000020 f 00000000 11bb33dd
tcm_inst_read inst rd 00000020 f 00000000 11bb33dd
shared_write data wr 00000031 f cafe0001 00000000
shared_read inst rd 00000031 f 00000000 cafe0001
nc_write data wr 00001000 3 12345678 00000000
nc_read_inst inst rd 00001000 f 00000000 ffff5678
nc_read_data data rd 00002000 f 00000000 ffff7fff
nc_read_again data rd 00001000 f 00000000 ffff5678
decode_move data dec 00000000 0 00001000 00000000
decode_nc_read inst rd 00000010 f 00000000 ffffffbf
decode_nc_write data wr 00000010 c 99887766 00000000
decode_nc_check data rd 00000010 f 00000000 9988ffbf
arbitration both rd 00003000 f 00003004 ffff3fff

// File: verif/tb_mem_subsys.sv
// testbench for the memory subsystem with a Wishbone peripheral model
`timescale 1ns/1ps

module tb_mem_subsys;

	localparam int TIMEOUT_CYCLES = 40;

	logic clk = 1'b0;
	logic rst_n_i;
	logic [31:0] tcm_addr_mask_i;
	logic [31:0] tcm_addr_value_i;
	logic inst_valid_i, inst_we_i, inst_ready_o;
	logic [29:0] inst_addr_i;
	logic [3:0] inst_sel_i;
	logic [31:0] inst_wdata_i, inst_rdata_o;
	logic data_valid_i, data_we_i, data_ready_o;
	logic [29:0] data_addr_i;
	logic [3:0] data_sel_i;
	logic [31:0] data_wdata_i, data_rdata_o;
	logic [29:0] wb_adr_o;
	logic [31:0] wb_dat_o;
	logic [31:0] wb_dat_i = 32'h0;
	logic wb_we_o, wb_stb_o;
	logic [3:0] wb_sel_o;
	logic wb_ack_i = 1'b0;

	// peripheral model state
	logic [31:0] periph [logic [29:0]];
	logic [31:0] merged;
	int ack_delay;
	logic ack_busy = 1'b0;
	int stb_cycles = 0;

	logic test_bad;
	logic timed_out = 1'b0;
	logic got_stb;
	int tests_run = 0;
	int tests_failed = 0;

	mem_subsys_top u_mem_subsys_top (.*);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		if (wb_stb_o) begin
			stb_cycles++;
		end
	end

	// unwritten peripheral words
	function automatic logic [31:0] fill_word(input logic [29:0] a);
		return ~{a, 2'b00};
	endfunction

	function automatic logic [31:0] periph_read(input logic [29:0] a);
		return periph.exists(a) ? periph[a] : fill_word(a);
	endfunction

	// ----------------------------------------------------------------------
	//  Wishbone peripheral, ack 1 to 4 cycles after stb
	// ----------------------------------------------------------------------
	always @(negedge clk) begin
		if (wb_ack_i) begin
			wb_ack_i = 1'b0;
		end else if (wb_stb_o) begin
			if (!ack_busy) begin
				ack_busy = 1'b1;
				ack_delay = $urandom_range(3, 0);
			end
			if (ack_delay == 0) begin
				merged = periph_read(wb_adr_o);
				if (wb_we_o) begin
					for (int i = 0; i < 4; i++) begin
						if (wb_sel_o[i]) merged[8*i +: 8] = wb_dat_o[8*i +: 8];
					end
					periph[wb_adr_o] = merged;
				end else begin
					wb_dat_i = merged;
				end
				wb_ack_i = 1'b1;
				ack_busy = 1'b0;
			end else begin
				ack_delay--;
			end
		end
	end

	task automatic check_word(input logic [8*24-1:0] name, input logic [31:0] exp,
			input logic [31:0] act);
		assert (act === exp) else begin
			$display("ERROR %0s expected %h actual %h", name, exp, act);
			test_bad = 1'b1;
		end
	endtask

	task automatic flag_timeout(input string what);
		$display("timeout while waiting for %s", what);
		timed_out = 1'b1;
		test_bad = 1'b1;
	endtask

	task automatic drive_port(input logic is_data, input logic valid, input logic we,
			input logic [29:0] addr, input logic [3:0] sel, input logic [31:0] wdata);
		if (is_data) begin
			data_valid_i = valid;
			data_we_i = we;
			data_addr_i = addr;
			data_sel_i = sel;
			data_wdata_i = wdata;
		end else begin
			inst_valid_i = valid;
			inst_we_i = we;
			inst_addr_i = addr;
			inst_sel_i = sel;
			inst_wdata_i = wdata;
		end
	endtask

	function automatic logic port_ready(input logic is_data);
		return is_data ? data_ready_o : inst_ready_o;
	endfunction

	// first cycle of a non-cached request on the external bus
	task automatic watch_stb(input logic [8*24-1:0] name, input logic we,
			input logic [29:0] addr, input logic [3:0] sel, input logic [31:0] wdata);
		if (wb_stb_o && !got_stb) begin
			got_stb = 1'b1;
			check_word(name, {2'b00, addr}, {2'b00, wb_adr_o});
			check_word(name, {31'd0, we}, {31'd0, wb_we_o});
			if (we) begin
				check_word(name, {28'd0, sel}, {28'd0, wb_sel_o});
				check_word(name, wdata, wb_dat_o);
			end
		end
	endtask

	task automatic single_access(input logic [8*24-1:0] name, input logic is_data,
			input logic we, input logic [29:0] addr, input logic [3:0] sel,
			input logic [31:0] wdata, input logic [31:0] exp);
		int cnt;
		int stb_before;
		logic through;
		through = (addr & tcm_addr_mask_i[31:2]) != tcm_addr_value_i[31:2];
		stb_before = stb_cycles;
		got_stb = 1'b0;
		cnt = 0;
		@(negedge clk);
		drive_port(is_data, 1'b1, we, addr, sel, wdata);
		#1;
		watch_stb(name, we, addr, sel, wdata);
		while (!port_ready(is_data)) begin
			@(negedge clk);
			#1;
			cnt++;
			if (cnt > TIMEOUT_CYCLES) begin
				flag_timeout("port ready");
				return;
			end
			watch_stb(name, we, addr, sel, wdata);
		end
		// accepted at the next rising edge, read data one cycle later
		@(negedge clk);
		drive_port(is_data, 1'b0, 1'b0, '0, '0, '0);
		if (!we) begin
			check_word(name, exp, is_data ? data_rdata_o : inst_rdata_o);
		end
		if (through) begin
			assert (got_stb) else begin
				$display("%0s: no Wishbone cycle for a non-cached access", name);
				test_bad = 1'b1;
			end
		end else begin
			assert (stb_cycles == stb_before) else begin
				$display("%0s: Wishbone strobe rose during a TCM access", name);
				test_bad = 1'b1;
			end
		end
	endtask

	task automatic both_read(input logic [8*24-1:0] name, input logic [29:0] d_addr,
			input logic [29:0] i_addr, input logic [31:0] d_exp);
		int cnt;
		logic d_acc, i_acc, d_ok, i_ok, data_first, first_set;
		logic [29:0] first_adr;
		d_acc = 0;
		i_acc = 0;
		d_ok = 0;
		i_ok = 0;
		data_first = 0;
		first_set = 0;
		first_adr = '0;
		cnt = 0;
		@(negedge clk);
		drive_port(1'b1, 1'b1, 1'b0, d_addr, 4'hf, '0);
		drive_port(1'b0, 1'b1, 1'b0, i_addr, 4'hf, '0);
		while (!(d_ok && i_ok)) begin
			#1;
			if (wb_stb_o && !first_set) begin
				first_set = 1'b1;
				first_adr = wb_adr_o;
			end
			if (data_ready_o && !d_acc) begin
				d_acc = 1'b1;
				data_first = !i_acc;
			end
			if (inst_ready_o && !i_acc) i_acc = 1'b1;
			@(negedge clk);
			if (d_acc && !d_ok) begin
				drive_port(1'b1, 1'b0, 1'b0, '0, '0, '0);
				check_word(name, d_exp, data_rdata_o);
				d_ok = 1'b1;
			end
			if (i_acc && !i_ok) begin
				drive_port(1'b0, 1'b0, 1'b0, '0, '0, '0);
				check_word(name, fill_word(i_addr), inst_rdata_o);
				i_ok = 1'b1;
			end
			cnt++;
			if (cnt > 2 * TIMEOUT_CYCLES) begin
				flag_timeout("both port ready signals");
				return;
			end
		end
		check_word(name, {2'b00, d_addr}, {2'b00, first_adr});
		assert (data_first) else begin
			$display("%0s: instruction request served before data request", name);
			test_bad = 1'b1;
		end
	endtask

	// ----------------------------------------------------------------------
	//  main flow
	// ----------------------------------------------------------------------
	initial begin
		int fd;
		int n;
		int seed_ret;
		string line;
		logic [8*24-1:0] name;
		logic [8*8-1:0] port;
		logic [8*8-1:0] op;
		logic [29:0] addr;
		logic [3:0] sel;
		logic [31:0] wdata;
		logic [31:0] exp;
		seed_ret = $urandom(32'ha969eb9b);
		rst_n_i = 1'b0;
		tcm_addr_mask_i = 32'hffff_fc00;
		tcm_addr_value_i = 32'h0;
		drive_port(1'b0, 1'b0, 1'b0, '0, '0, '0);
		drive_port(1'b1, 1'b0, 1'b0, '0, '0, '0);
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n_i = 1'b1;

		test_bad = 1'b0;
		check_word("reset_state", 32'h0, {31'd0, wb_stb_o});
		check_word("reset_state", 32'h0, inst_rdata_o);
		check_word("reset_state", 32'h0, data_rdata_o);
		tests_run++;
		if (test_bad) tests_failed++;
		$display("reset_state %0s", test_bad ? "failed" : "ok");

		fd = $fopen("verif/mem_vectors.txt", "r");
		if (fd == 0) begin
			$display("cannot open the vector file");
			tests_failed++;
		end else begin
			while (!$feof(fd) && !timed_out) begin
				line = "";
				n = $fgets(line, fd);
				if (line.len() < 2 || line[0] == "#") continue;
				n = $sscanf(line, "%s %s %s %h %h %h %h", name, port, op, addr, sel,
					wdata, exp);
				test_bad = 1'b0;
				if (n != 7) begin
					$display("malformed line in the vector file");
					test_bad = 1'b1;
				end else if (op == "dec") begin
					@(negedge clk);
					tcm_addr_value_i = wdata;
				end else if (port == "both") begin
					both_read(name, addr, wdata[29:0], exp);
				end else if (op == "wr" || op == "rd") begin
					single_access(name, port == "data", op == "wr", addr, sel, wdata, exp);
				end else begin
					$display("%0s: unknown operation in the vector file", name);
					test_bad = 1'b1;
				end
				tests_run++;
				if (test_bad) tests_failed++;
				$display("%0s %0s", name, test_bad ? "failed" : "ok");
			end
			$fclose(fd);
		end

		$display("tests run %0d, failed %0d", tests_run, tests_failed);
		if (tests_failed == 0 && tests_run > 1) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule
